/* hw/nd120_io_cfg.svh */
////////////////////////////////////////
// Fixed board straps and timer constants
////////////////////////////////////////
`ifndef ND120_IO_CFG_SVH
`define ND120_IO_CFG_SVH

// Print version 011 is board revision D
`define ND120_PRINT_VERSION 3'b011

// Strap 9 down to strap 5
// A fitted strap pulls its bit low
`define ND120_STRAPS 5'b00101

// ALD boot switch, 4 loads from paper tape at 400
`define ND120_ALD_SWITCH 4'b0100

// Clock cycles per RTC tick, short for simulation
`define ND120_RTC_DIVIDE 16'd40

// Wishbone word address width
`define ND120_ADDR_W 3

`endif

/* hw/nd120_io_pkg.sv */
////////////////////////////////////////
// Shared types of the ND120 I/O block
// Imported by the bus FSM and register blocks
////////////////////////////////////////
package nd120_io_pkg;

  // Bus FSM states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,  // Waiting for cyc and stb
    ACK     = 2'd1,  // Single ack cycle
    TX_WAIT = 2'd2   // Held off by a full transmitter
  } io_state_e;

  // Decoded register operations
  // Word address 0 IOC, 1 ALD, 2 INR, 3 TXD, 4 RXD, 5 status
  typedef enum logic [2:0] {
    NONE    = 3'd0,  // Unused address or wrong direction
    WR_IOC  = 3'd1,
    RD_IOC  = 3'd2,
    RD_ALD  = 3'd3,  // Straps, print version, boot switch
    RD_INR  = 3'd4,  // External input lines
    WR_TXD  = 3'd5,  // Terminal #1 transmit character
    RD_RXD  = 3'd6,  // Terminal #1 receive character
    RD_STAT = 3'd7   // Terminal #1 flags
  } io_op_e;

  // IOC control register, bit 7 first
  typedef struct packed {
    logic rtc_reset;    // Restart real-time clock
    logic scons_n;      // Terminal #1 as console
    logic led_red_n;    // Master clear enable, red LED
    logic led_green_n;  // Init done, green LED
    logic clk_int_req;  // Clock interrupt from trap handler
    logic en_tx_int;    // Level 10 enable
    logic en_rx_int;    // Level 12 enable
    logic en_clk_int;   // Level 13 enable
  } ioc_t;

endpackage

/* hw/io_strobe_if.sv */
////////////////////////////////////////
// Register operation from bus FSM to data blocks
////////////////////////////////////////
`timescale 1ns/1ps

interface io_strobe_if;
  import nd120_io_pkg::*;

  io_op_e      op;          // Decoded operation
  logic [15:0] wdata;       // Write data from the master
  logic        strobe;      // One cycle, update edge
  logic [15:0] reg_rdata;   // IOC, ALD, INR readback
  logic [15:0] term_rdata;  // Terminal readback
  logic        tx_full;     // Transmit holding register busy

  // Bus FSM side
  modport ctrl (
    output op, wdata, strobe,
    input  reg_rdata, term_rdata, tx_full
  );

  // IOC register block
  modport regs (
    input  op, wdata, strobe,
    output reg_rdata
  );

  // Terminal #1 buffers
  modport term (
    input  op, wdata, strobe,
    output term_rdata, tx_full
  );

endinterface

/* hw/io_bus_fsm.sv */
////////////////////////////////////////
// Wishbone classic slave for the I/O block
// Decodes word addresses into register strobes
////////////////////////////////////////
`timescale 1ns/1ps
`include "nd120_io_cfg.svh"

module io_bus_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`ND120_ADDR_W-1:0] wb_adr,
  input  logic [15:0]              wb_dat_w,
  output logic [15:0]              wb_dat_r,
  output logic                     wb_ack,
  io_strobe_if.ctrl                bus
);
  import nd120_io_pkg::*;

  io_state_e state;
  io_state_e state_nxt;
  logic      req;       // Master cycle active
  logic      tx_hold;   // Transmit write must wait

  assign req = wb_cyc & wb_stb;

  // Address decode, master holds adr and we until ack
  always_comb begin
    bus.op = NONE;
    if (req) begin
      case (wb_adr)
        3'd0:    bus.op = wb_we ? WR_IOC : RD_IOC;
        3'd1:    bus.op = wb_we ? NONE : RD_ALD;   // Read only
        3'd2:    bus.op = wb_we ? NONE : RD_INR;
        3'd3:    bus.op = wb_we ? WR_TXD : NONE;   // Write only
        3'd4:    bus.op = wb_we ? NONE : RD_RXD;
        3'd5:    bus.op = wb_we ? NONE : RD_STAT;
        default: bus.op = NONE;                    // Reads as zero
      endcase
    end
  end

  assign bus.wdata = wb_dat_w;
  assign tx_hold   = (bus.op == WR_TXD) & bus.tx_full;

  // Next state and strobe
  always_comb begin
    state_nxt  = state;
    bus.strobe = 1'b0;
    case (state)
      IDLE: begin
        if (req) begin
          if (tx_hold) begin
            state_nxt = TX_WAIT;  // No strobe yet
          end else begin
            bus.strobe = 1'b1;    // Update at the edge that raises ack
            state_nxt  = ACK;
          end
        end
      end
      TX_WAIT: begin
        if (!req) begin
          state_nxt = IDLE;       // Master gave up
        end else if (!bus.tx_full) begin
          bus.strobe = 1'b1;
          state_nxt  = ACK;
        end
      end
      ACK:     state_nxt = IDLE;  // Master drops stb next cycle
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= IDLE;
    else       state <= state_nxt;
  end

  assign wb_ack = (state == ACK);  // Exactly one cycle

  // Readback select, valid while ack is high
  always_comb begin
    case (bus.op)
      RD_IOC, RD_ALD, RD_INR: wb_dat_r = bus.reg_rdata;
      RD_RXD, RD_STAT:        wb_dat_r = bus.term_rdata;
      default:                wb_dat_r = 16'h0000;
    endcase
  end

endmodule

/* hw/rtc_timer.sv */
////////////////////////////////////////
// Real-time-clock tick divider
// Sets a sticky pending flag every divide period
////////////////////////////////////////
`timescale 1ns/1ps
`include "nd120_io_cfg.svh"

module rtc_timer (
  input  logic clk,
  input  logic reset,
  input  logic rtc_clear,    // IOC write with rtc_reset
  output logic rtc_pending   // Tick seen and not yet cleared
);

  localparam logic [15:0] RELOAD = `ND120_RTC_DIVIDE - 16'd1;  // Terminal count lands on the Nth edge

  logic [15:0] cnt;        // Down counter

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt         <= RELOAD;
      rtc_pending <= 1'b0;
    end else if (rtc_clear) begin
      cnt         <= RELOAD;   // Restart the period
      rtc_pending <= 1'b0;
    end else if (cnt == 16'd0) begin
      cnt         <= RELOAD;   // Free running
      rtc_pending <= 1'b1;     // Sticky until cleared
    end else begin
      cnt <= cnt - 16'd1;
    end
  end

endmodule

/* hw/io_reg.sv */
////////////////////////////////////////
// IOC register, ALD and INR readback
// Also forms the three interrupt requests
////////////////////////////////////////
`timescale 1ns/1ps
`include "nd120_io_cfg.svh"

module io_reg (
  input  logic               clk,
  input  logic               reset,
  io_strobe_if.regs          bus,
  input  logic [7:0]         inr,          // External input lines
  input  logic               cx_n,         // Console switch
  input  logic               tbmt,         // Transmit buffer empty
  input  logic               da,           // Receive data available
  input  logic               rtc_pending,
  output nd120_io_pkg::ioc_t ioc,
  output logic               rtc_clear,    // Restart RTC
  output logic               bint10_n,
  output logic               bint12_n,
  output logic               bint13_n
);
  import nd120_io_pkg::*;

  localparam logic [4:0] STRAPS = `ND120_STRAPS;  // Strap 9 in bit 4

  logic        ioc_wr;
  logic [15:0] ald;

  assign ioc_wr = bus.strobe & (bus.op == WR_IOC);

  always_ff @(posedge clk) begin
    if (reset) begin
      ioc <= '0;           // LEDs on, console off, no enables
    end else if (ioc_wr) begin
      ioc <= ioc_t'(bus.wdata[7:0]);
    end
  end

  // Pulses with the write while bit 7 itself stays in the register
  assign rtc_clear = ioc_wr & bus.wdata[7];

  // ALD word
  assign ald = {
    3'b111,                    // Pulled high
    STRAPS[0],                 // Strap 5
    STRAPS[1], STRAPS[2],      // Straps 6, 7
    STRAPS[3], STRAPS[4],      // Straps 8, 9
    cx_n,
    `ND120_PRINT_VERSION,
    `ND120_ALD_SWITCH          // Boot selection
  };

  always_comb begin
    case (bus.op)
      RD_IOC:  bus.reg_rdata = {8'h00, ioc};
      RD_ALD:  bus.reg_rdata = ald;
      RD_INR:  bus.reg_rdata = {8'h00, inr};
      default: bus.reg_rdata = 16'h0000;
    endcase
  end

  // Level 10 on transmitter empty
  assign bint10_n = ~(ioc.en_tx_int & tbmt);

  // Level 12 on receive in console mode only
  assign bint12_n = ~(ioc.scons_n & ioc.en_rx_int & da);

  // Level 13 on software request or RTC tick
  assign bint13_n = ~(ioc.en_clk_int & (ioc.clk_int_req | rtc_pending));

endmodule

/* hw/term_buffer.sv */
////////////////////////////////////////
// Terminal #1 transmit and receive holding registers
////////////////////////////////////////
`timescale 1ns/1ps

module term_buffer (
  input  logic       clk,
  input  logic       reset,
  io_strobe_if.term  bus,
  input  logic [7:0] rx_data,
  input  logic       rx_valid,   // One character per pulse
  output logic [7:0] tx_data,
  output logic       tx_valid,
  input  logic       tx_ready,   // Sink takes tx_data
  output logic       tbmt,       // Transmit buffer empty
  output logic       da          // Data available
);
  import nd120_io_pkg::*;

  logic [7:0] tx_hold;
  logic [7:0] rx_hold;
  logic       tx_full;

  // Transmit side
  always_ff @(posedge clk) begin
    if (bus.strobe && (bus.op == WR_TXD)) begin
      tx_hold <= bus.wdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_full <= 1'b0;
    end else if (bus.strobe && (bus.op == WR_TXD)) begin
      tx_full <= 1'b1;
    end else if (tx_ready) begin
      tx_full <= 1'b0;        // Character taken
    end
  end

  assign tx_data     = tx_hold;
  assign tx_valid    = tx_full;
  assign tbmt        = ~tx_full;
  assign bus.tx_full = tx_full;   // Back-pressure to the bus FSM

  // Receive side
  always_ff @(posedge clk) begin
    if (rx_valid) rx_hold <= rx_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      da <= 1'b0;
    end else if (rx_valid) begin
      da <= 1'b1;             // New character wins over a read
    end else if (bus.strobe && (bus.op == RD_RXD)) begin
      da <= 1'b0;
    end
  end

  always_comb begin
    case (bus.op)
      RD_RXD:  bus.term_rdata = {8'h00, rx_hold};
      RD_STAT: bus.term_rdata = {14'd0, da, tbmt};
      default: bus.term_rdata = 16'h0000;
    endcase
  end

endmodule

/* hw/nd120_io.sv */
////////////////////////////////////////
// ND120 I/O register block, Wishbone top
// Plain ports for board and bus connection
////////////////////////////////////////
`timescale 1ns/1ps

module nd120_io (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [2:0]  wb_adr,     // Word address
  input  logic [15:0] wb_dat_w,
  output logic [15:0] wb_dat_r,
  output logic        wb_ack,
  input  logic [7:0]  inr,
  input  logic        cx_n,
  input  logic [7:0]  rx_data,
  input  logic        rx_valid,
  output logic [7:0]  tx_data,
  output logic        tx_valid,
  input  logic        tx_ready,
  output logic        bint10_n,
  output logic        bint12_n,
  output logic        bint13_n,
  output logic        console_n,
  output logic        emcl_n,
  output logic [1:0]  ioled       // 0 red, 1 green
);
  import nd120_io_pkg::*;

  io_strobe_if bus ();

  ioc_t ioc;
  logic rtc_clear;
  logic rtc_pending;
  logic tbmt;
  logic da;

  io_bus_fsm io_bus_fsm_i (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .bus      (bus.ctrl)
  );

  rtc_timer rtc_timer_i (
    .clk         (clk),
    .reset       (reset),
    .rtc_clear   (rtc_clear),
    .rtc_pending (rtc_pending)
  );

  io_reg io_reg_i (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus.regs),
    .inr         (inr),
    .cx_n        (cx_n),
    .tbmt        (tbmt),
    .da          (da),
    .rtc_pending (rtc_pending),
    .ioc         (ioc),
    .rtc_clear   (rtc_clear),
    .bint10_n    (bint10_n),
    .bint12_n    (bint12_n),
    .bint13_n    (bint13_n)
  );

  term_buffer term_buffer_i (
    .clk      (clk),
    .reset    (reset),
    .bus      (bus.term),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tbmt     (tbmt),
    .da       (da)
  );

  // Panel and console lines straight from the IOC
  assign console_n = ioc.scons_n;
  assign emcl_n    = ioc.led_red_n;                    // Red LED doubles as master clear
  assign ioled     = {ioc.led_green_n, ioc.led_red_n};

endmodule

/* sim/tb_clock.sv */
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD  = 10;  // 20 ns period
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Synchronous reset, released just after an edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

/* sim/nd120_io_assert.sv */
////////////////////////////////////////
// Wishbone and interrupt line properties
// Bound into the I/O top from the testbench
////////////////////////////////////////
`timescale 1ns/1ps

module nd120_io_assert (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic bint10_n,
  input logic bint12_n,
  input logic bint13_n
);

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (
    @(posedge clk) disable iff (reset) wb_ack |=> !wb_ack
  ) else $error("wb_ack stayed high for more than one cycle");

  // Slave only answers an active master cycle
  ack_needs_request: assert property (
    @(posedge clk) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb)
  ) else $error("wb_ack raised without wb_cyc and wb_stb");

  // IOC cleared by reset, so no request line may be active
  bint_idle_after_reset: assert property (
    @(posedge clk) reset |=> (bint10_n && bint12_n && bint13_n)
  ) else $error("interrupt request line low right after reset");

endmodule

/* sim/tb_nd120_io.sv */
////////////////////////////////////////
// Directed testbench for the ND120 I/O block
// Drives the Wishbone port and board lines
////////////////////////////////////////
`timescale 1ns/1ps
`include "nd120_io_cfg.svh"

module tb_nd120_io;
  import nd120_io_pkg::*;

  localparam int RTC_DIV     = int'(`ND120_RTC_DIVIDE);
  localparam int NUM_TESTS   = 5;
  localparam int ACK_LIMIT   = 100;                               // Cycles per bus access
  localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 2 * RTC_DIV) * 20;

  // Word addresses
  localparam logic [2:0] ADR_IOC  = 3'd0;
  localparam logic [2:0] ADR_ALD  = 3'd1;
  localparam logic [2:0] ADR_INR  = 3'd2;
  localparam logic [2:0] ADR_TXD  = 3'd3;
  localparam logic [2:0] ADR_RXD  = 3'd4;
  localparam logic [2:0] ADR_STAT = 3'd5;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic [7:0]  inr;
  logic        cx_n;
  logic [7:0]  rx_data;
  logic        rx_valid;
  logic [7:0]  tx_data;
  logic        tx_valid;
  logic        tx_ready;
  logic        bint10_n;
  logic        bint12_n;
  logic        bint13_n;
  logic        console_n;
  logic        emcl_n;
  logic [1:0]  ioled;

  int     errors;
  int     checks;
  string  test_name;
  integer seed;

  tb_clock clock_i (.clk(clk), .reset(reset));

  nd120_io nd120_io_i (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .inr(inr), .cx_n(cx_n), .rx_data(rx_data), .rx_valid(rx_valid),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .bint10_n(bint10_n), .bint12_n(bint12_n), .bint13_n(bint13_n),
    .console_n(console_n), .emcl_n(emcl_n), .ioled(ioled)
  );

  bind nd120_io nd120_io_assert assert_i (
    .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .bint10_n(bint10_n), .bint12_n(bint12_n), .bint13_n(bint13_n)
  );

  task automatic step_clock();
    @(posedge clk);
    #1;                                  // Drive and sample clear of the edge
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_ioc(input string name, input ioc_t exp, input ioc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %b, actual %b", test_name, name, exp, act);
    end
  endtask

  // One classic cycle, stb held through the ack cycle
  task automatic run_cycle(input logic we, input logic [2:0] adr, input logic [15:0] wdat,
                           output logic [15:0] rdat);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    do begin
      step_clock();
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      errors++;
      $display("[%s] no ack from address %0d after %0d cycles", test_name, adr, waited);
    end
    rdat = wb_dat_r;                     // Valid while ack is high
    step_clock();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [15:0] wdat);
    logic [15:0] unused;
    run_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [15:0] rdat);
    run_cycle(1'b0, adr, 16'h0000, rdat);
  endtask

  // ALD layout from the board description
  function automatic logic [15:0] ald_expected(input logic cx);
    logic [4:0]  s;
    logic [15:0] w;
    s        = `ND120_STRAPS;            // Strap 5 in bit 0
    w        = 16'h0000;
    w[15:13] = 3'b111;
    w[12]    = s[0];
    w[11]    = s[1];                     // Strap 6
    w[10]    = s[2];
    w[9]     = s[3];
    w[8]     = s[4];                     // Strap 9
    w[7]     = cx;
    w[6:4]   = `ND120_PRINT_VERSION;
    w[3:0]   = `ND120_ALD_SWITCH;
    return w;
  endfunction

  // Write IOC, read it back, check panel and console lines
  task automatic load_ioc(input ioc_t v);
    logic [15:0] rd;
    wb_write(ADR_IOC, {8'h00, v});
    wb_read(ADR_IOC, rd);
    check_ioc("IOC readback", v, ioc_t'(rd[7:0]));
    check_word("IOC upper byte", 16'h0000, {8'h00, rd[15:8]});
    check_bit("ioled[0] red", v.led_red_n, ioled[0]);
    check_bit("ioled[1] green", v.led_green_n, ioled[1]);
    check_bit("emcl_n", v.led_red_n, emcl_n);
    check_bit("console_n", v.scons_n, console_n);
  endtask

  task automatic reset_and_ioc();
    logic [15:0] rd;
    ioc_t        v;
    test_name = "reset_and_ioc";
    check_bit("bint10_n after reset", 1'b1, bint10_n);
    check_bit("bint12_n after reset", 1'b1, bint12_n);
    check_bit("bint13_n after reset", 1'b1, bint13_n);
    check_bit("ioled[0] after reset", 1'b0, ioled[0]);
    check_bit("ioled[1] after reset", 1'b0, ioled[1]);
    check_bit("console_n after reset", 1'b0, console_n);
    wb_read(ADR_IOC, rd);
    check_ioc("IOC after reset", '0, ioc_t'(rd[7:0]));
    v             = '0;
    v.scons_n     = 1'b1;                // Console on, green LED off
    v.led_green_n = 1'b1;
    load_ioc(v);
    v           = '0;
    v.led_red_n = 1'b1;                  // Red LED off only
    load_ioc(v);
    load_ioc('0);
  endtask

  task automatic ald_and_inr();
    logic [15:0] rd;
    logic [31:0] rnd;
    test_name = "ald_and_inr";
    cx_n = 1'b0;
    wb_read(ADR_ALD, rd);
    check_word("ALD with cx_n low", ald_expected(1'b0), rd);
    cx_n = 1'b1;
    wb_read(ADR_ALD, rd);
    check_word("ALD with cx_n high", ald_expected(1'b1), rd);
    repeat (3) begin
      rnd = $random(seed);
      inr = rnd[7:0];
      wb_read(ADR_INR, rd);
      check_word("INR readback", {8'h00, rnd[7:0]}, rd);
    end
  endtask

  task automatic terminal_tx();
    logic [15:0] rd;
    logic [31:0] rnd;
    logic [7:0]  c1;
    logic [7:0]  c2;
    logic        early_ack;
    ioc_t        v;
    test_name = "terminal_tx";
    rnd       = $random(seed);
    c1        = rnd[7:0];
    c2        = rnd[15:8];
    early_ack = 1'b0;
    tx_ready  = 1'b0;                    // Sink busy
    wb_write(ADR_TXD, {8'h00, c1});
    check_bit("tx_valid after first write", 1'b1, tx_valid);
    check_word("tx_data after first write", {8'h00, c1}, {8'h00, tx_data});
    wb_read(ADR_STAT, rd);
    check_word("status with full transmitter", 16'h0000, rd);
    fork
      wb_write(ADR_TXD, {8'h00, c2});    // Must stall in TX_WAIT
      begin
        repeat (6) begin
          step_clock();
          if (wb_ack) early_ack = 1'b1;
        end
        tx_ready = 1'b1;                 // Let the first character go
      end
    join
    check_bit("no ack while tx_ready low", 1'b0, early_ack);
    check_word("tx_data after second write", {8'h00, c2}, {8'h00, tx_data});
    check_bit("tx_valid after drain", 1'b0, tx_valid);
    wb_read(ADR_STAT, rd);
    check_word("status with empty transmitter", 16'h0001, rd);
    check_bit("bint10_n without enable", 1'b1, bint10_n);
    v           = '0;
    v.en_tx_int = 1'b1;
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint10_n with en_tx_int", 1'b0, bint10_n);
    wb_write(ADR_IOC, 16'h0000);
    check_bit("bint10_n disabled again", 1'b1, bint10_n);
  endtask

  task automatic terminal_rx();
    logic [15:0] rd;
    logic [31:0] rnd;
    ioc_t        v;
    test_name = "terminal_rx";
    rnd       = $random(seed);
    rx_data   = rnd[7:0];
    rx_valid  = 1'b1;
    step_clock();
    rx_valid  = 1'b0;
    rx_data   = ~rnd[7:0];               // Holding register keeps the old one
    wb_read(ADR_STAT, rd);
    check_word("status with data available", 16'h0003, rd);
    v           = '0;
    v.en_rx_int = 1'b1;
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint12_n enable without console", 1'b1, bint12_n);
    v         = '0;
    v.scons_n = 1'b1;
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint12_n console without enable", 1'b1, bint12_n);
    v.en_rx_int = 1'b1;
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint12_n console and enable", 1'b0, bint12_n);
    wb_read(ADR_RXD, rd);
    check_word("received character", {8'h00, rnd[7:0]}, rd);
    check_bit("bint12_n after RXD read", 1'b1, bint12_n);
    wb_read(ADR_STAT, rd);
    check_word("status after RXD read", 16'h0001, rd);
    wb_write(ADR_IOC, 16'h0000);
  endtask

  task automatic rtc_tick();
    ioc_t v;
    int   n;
    test_name    = "rtc_tick";
    v            = '0;
    v.rtc_reset  = 1'b1;
    v.en_clk_int = 1'b1;
    wb_write(ADR_IOC, {8'h00, v});       // Clear pending, restart divider
    check_bit("bint13_n after RTC restart", 1'b1, bint13_n);
    n = 0;
    while (bint13_n && n < RTC_DIV + 10) begin
      step_clock();
      n++;
    end
    check_bit("bint13_n on RTC tick", 1'b0, bint13_n);
    check_bit("RTC tick inside one period", 1'b1, (n >= RTC_DIV - 4) && (n <= RTC_DIV + 4));
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint13_n after rtc_reset write", 1'b1, bint13_n);
    v             = '0;
    v.en_clk_int  = 1'b1;
    v.clk_int_req = 1'b1;                // Software clock request
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint13_n with clk_int_req", 1'b0, bint13_n);
    v.en_clk_int = 1'b0;
    wb_write(ADR_IOC, {8'h00, v});
    check_bit("bint13_n request without enable", 1'b1, bint13_n);
    wb_write(ADR_IOC, 16'h0000);
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    seed      = 32'hface;
    test_name = "init";
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = 3'd0;
    wb_dat_w  = 16'h0000;
    inr       = 8'h00;
    cx_n      = 1'b1;
    rx_data   = 8'h00;
    rx_valid  = 1'b0;
    tx_ready  = 1'b1;                    // Sink idle
    wait (reset == 1'b0);
    step_clock();
    reset_and_ioc();
    ald_and_inr();
    terminal_tx();
    terminal_rx();
    rtc_tick();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Bounds the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns, stopped by watchdog", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* nd120_io.f */
+incdir+hw
hw/nd120_io_pkg.sv
hw/io_strobe_if.sv
hw/io_bus_fsm.sv
hw/rtc_timer.sv
hw/io_reg.sv
hw/term_buffer.sv
hw/nd120_io.sv
sim/tb_clock.sv
sim/nd120_io_assert.sv
sim/tb_nd120_io.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the nd120_io testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_nd120_io \
  -f nd120_io.f -o sim_nd120_io > build.log 2>&1 \
  || { cat build.log; echo "run_sim: build error"; exit 1; }
./obj_dir/sim_nd120_io > sim.log 2>&1
cat sim.log
grep -qx "Simulation passed" sim.log \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }
